// File: logic/pic_macros.svh
`ifndef PIC_MACROS_SVH
`define PIC_MACROS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Widths.
`define PIC_DATA_W          8
`define PIC_IRQ_COUNT       8
`define PIC_IRQ_NUM_W       3
`define PIC_CALL_BASE_W     3

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Command word fields.
`define PIC_ICW1_LTIM       3
`define PIC_ICW1_ADI        2
`define PIC_ICW1_SNGL       1
`define PIC_ICW1_IC4        0
`define PIC_ICW4_AEOI       1
`define PIC_OCW3_POLL       2
`define PIC_OCW2_EOI_MSB    6
`define PIC_OCW2_EOI_LSB    5
`define PIC_EOI_NONSPECIFIC 2'b01
`define PIC_EOI_SPECIFIC    2'b11
`define PIC_POLL_FLAG       5'b10000 // Top five bits of the poll word.

`endif

// File: logic/pic_cmd_pkg.sv
`include "pic_macros.svh"

package pic_cmd_pkg;

	typedef logic [`PIC_DATA_W-1:0]      data_t;
	typedef logic [`PIC_IRQ_COUNT-1:0]   irq_vec_t;   // One bit per level.
	typedef logic [`PIC_IRQ_NUM_W-1:0]   irq_num_t;
	typedef logic [`PIC_CALL_BASE_W-1:0] call_base_t; // A7 to A5 from ICW1.

	// Which initialization word is expected next.
	typedef enum logic [1:0] {
		icw_ready,
		icw_expect_2,
		icw_expect_3,
		icw_expect_4
	} icw_state_t;

endpackage

// File: logic/pic_ack_pkg.sv
package pic_ack_pkg;

	// Acknowledge and poll sequence.
	typedef enum logic [2:0] {
		ack_idle,
		ack_pulse_1,
		ack_pulse_2,
		ack_pulse_3,
		ack_poll
	} ack_state_t;

endpackage

// File: logic/icw_sequencer.sv
`timescale 1ns/1ps
`include "pic_macros.svh"

module icw_sequencer (
	input  logic                    clk,
	input  logic                    rst_n,
	input  pic_cmd_pkg::data_t      internal_data_bus,
	input  logic                    icw_1,
	input  logic                    icw_2_4,
	output logic                    init_done,
	output pic_cmd_pkg::call_base_t call_base,
	output logic                    interval_4,
	output logic                    single_mode,
	output logic                    level_triggered,
	output logic                    auto_eoi,
	output pic_cmd_pkg::data_t      vector_high
);
	import pic_cmd_pkg::*;

	icw_state_t state;
	icw_state_t next_state;
	logic       icw4_needed;
	logic       icw_next_write;

	assign icw_next_write = icw_2_4 & ~icw_1;
	assign init_done = (state == icw_ready);

	always_comb
	begin
		next_state = state;
		if (icw_1)
			next_state = icw_expect_2; // ICW1 restarts the sequence.
		else if (icw_2_4)
		begin
			case (state)
				icw_expect_2: next_state = !single_mode ? icw_expect_3 :
					(icw4_needed ? icw_expect_4 : icw_ready);
				icw_expect_3: next_state = icw4_needed ? icw_expect_4 : icw_ready;
				icw_expect_4: next_state = icw_ready;
				default:      next_state = icw_ready;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			state           <= icw_ready;
			call_base       <= '0;
			interval_4      <= 1'b0;
			single_mode     <= 1'b0;
			level_triggered <= 1'b0;
			icw4_needed     <= 1'b0;
			auto_eoi        <= 1'b0;
			vector_high     <= '0;
		end
		else
		begin
			state <= next_state;
			if (icw_1)
			begin
				call_base       <= internal_data_bus[`PIC_DATA_W-1 -: `PIC_CALL_BASE_W];
				level_triggered <= internal_data_bus[`PIC_ICW1_LTIM];
				interval_4      <= internal_data_bus[`PIC_ICW1_ADI];
				single_mode     <= internal_data_bus[`PIC_ICW1_SNGL];
				icw4_needed     <= internal_data_bus[`PIC_ICW1_IC4];
			end
			if (icw_next_write && state == icw_expect_2)
				vector_high <= internal_data_bus;
			if (icw_next_write && state == icw_expect_4)
				auto_eoi <= internal_data_bus[`PIC_ICW4_AEOI];
		end
	end

endmodule

// File: logic/ocw_registers.sv
`timescale 1ns/1ps
`include "pic_macros.svh"

module ocw_registers (
	input  logic                  clk,
	input  logic                  rst_n,
	input  pic_cmd_pkg::data_t    internal_data_bus,
	input  logic                  init_done,
	input  logic                  ocw_1,
	input  logic                  ocw_2,
	input  logic                  ocw_3,
	input  logic                  auto_eoi,
	input  logic                  ack_done,
	input  pic_cmd_pkg::irq_vec_t ack_levels,
	input  pic_cmd_pkg::irq_vec_t highest_level_in_service,
	output pic_cmd_pkg::irq_vec_t interrupt_mask,
	output logic                  enable_read_register,
	output logic                  read_register_isr_or_irr,
	output logic                  poll_command,
	output pic_cmd_pkg::irq_vec_t end_of_interrupt
);
	import pic_cmd_pkg::*;

	logic     ocw_1_write;
	logic     ocw_2_write;
	logic     ocw_3_write;
	irq_num_t eoi_level;

	// OCWs count only once the ICW sequence is complete.
	assign ocw_1_write  = ocw_1 & init_done;
	assign ocw_2_write  = ocw_2 & init_done;
	assign ocw_3_write  = ocw_3 & init_done;
	assign eoi_level    = internal_data_bus[`PIC_IRQ_NUM_W-1:0];
	assign poll_command = ocw_3_write & internal_data_bus[`PIC_OCW3_POLL];

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			interrupt_mask           <= '0;
			enable_read_register     <= 1'b0;
			read_register_isr_or_irr <= 1'b0;
		end
		else
		begin
			if (ocw_1_write)
				interrupt_mask <= internal_data_bus;
			if (ocw_3_write)
			begin
				enable_read_register     <= internal_data_bus[1]; // RR.
				read_register_isr_or_irr <= internal_data_bus[0]; // RIS.
			end
		end
	end

	always_comb
	begin
		end_of_interrupt = '0;
		if (auto_eoi && ack_done)
			end_of_interrupt = ack_levels;
		else if (ocw_2_write)
		begin
			case (internal_data_bus[`PIC_OCW2_EOI_MSB:`PIC_OCW2_EOI_LSB])
				`PIC_EOI_NONSPECIFIC: end_of_interrupt = highest_level_in_service;
				`PIC_EOI_SPECIFIC:    end_of_interrupt = irq_vec_t'(1) << eoi_level;
				default:              end_of_interrupt = '0;
			endcase
		end
	end

endmodule

// File: logic/ack_sequencer.sv
`timescale 1ns/1ps

module ack_sequencer (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    icw_1,
	input  logic                    inta_n,
	input  logic                    read,
	input  logic                    poll_command,
	input  pic_cmd_pkg::irq_vec_t   interrupt,
	output pic_ack_pkg::ack_state_t ack_state,
	output pic_cmd_pkg::irq_vec_t   ack_levels,
	output logic                    ack_done,
	output logic                    latch_in_service,
	output logic                    freeze,
	output pic_cmd_pkg::irq_vec_t   clear_interrupt_request,
	output logic                    interrupt_to_cpu
);
	import pic_cmd_pkg::*;
	import pic_ack_pkg::*;

	ack_state_t state;
	ack_state_t next_state;
	logic       prev_inta_n;
	logic       prev_read;
	logic       inta_fall;
	logic       inta_rise;
	logic       read_fall;

	assign inta_fall = prev_inta_n & ~inta_n;
	assign inta_rise = ~prev_inta_n & inta_n;
	assign read_fall = prev_read & ~read;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Acknowledge state machine.
	always_comb
	begin
		next_state = state;
		case (state)
			ack_idle:
				if (poll_command)
					next_state = ack_poll;
				else if (inta_fall)
					next_state = ack_pulse_1;
			ack_pulse_1: if (inta_rise) next_state = ack_pulse_2;
			ack_pulse_2: if (inta_rise) next_state = ack_pulse_3;
			ack_pulse_3: if (inta_rise) next_state = ack_idle;
			ack_poll:    if (read_fall) next_state = ack_idle;
			default:     next_state = ack_idle;
		endcase
	end

	assign ack_state        = state;
	assign latch_in_service = (state == ack_idle) && (next_state != ack_idle);
	assign ack_done         = (state != ack_idle) && (next_state == ack_idle);
	assign freeze           = (next_state != ack_idle);
	assign clear_interrupt_request = icw_1 ? {$bits(irq_vec_t){1'b1}} :
		(latch_in_service ? interrupt : '0);

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			state            <= ack_idle;
			prev_inta_n      <= 1'b1;
			prev_read        <= 1'b0;
			ack_levels       <= '0;
			interrupt_to_cpu <= 1'b0;
		end
		else
		begin
			state       <= next_state;
			prev_inta_n <= inta_n;
			prev_read   <= read;
			if (latch_in_service)
				ack_levels <= interrupt; // Request being served.
			else if (ack_done)
				ack_levels <= '0;
			if (interrupt != '0)
				interrupt_to_cpu <= 1'b1;
			else if (ack_done)
				interrupt_to_cpu <= 1'b0;
		end
	end

endmodule

// File: logic/vector_driver.sv
`timescale 1ns/1ps
`include "pic_macros.svh"

module vector_driver (
	input  pic_ack_pkg::ack_state_t ack_state,
	input  logic                    inta_n,
	input  logic                    read,
	input  pic_cmd_pkg::irq_vec_t   ack_levels,
	input  pic_cmd_pkg::call_base_t call_base,
	input  logic                    interval_4,
	input  pic_cmd_pkg::data_t      vector_high,
	output logic                    out_control_logic_data,
	output pic_cmd_pkg::data_t      control_logic_data
);
	import pic_cmd_pkg::*;
	import pic_ack_pkg::*;

	irq_num_t level_num;

	// Lowest set bit wins.
	always_comb
	begin
		level_num = '0;
		for (int i = `PIC_IRQ_COUNT - 1; i >= 0; i--)
			if (ack_levels[i])
				level_num = irq_num_t'(i);
	end

	always_comb
	begin
		out_control_logic_data = 1'b0;
		control_logic_data     = '0;
		case (ack_state)
			ack_pulse_2:
				if (!inta_n)
				begin
					out_control_logic_data = 1'b1;
					if (interval_4)
						control_logic_data = {call_base, level_num, 2'b00};
					else
						control_logic_data = {call_base[2:1], level_num, 3'b000};
				end
			ack_pulse_3:
				if (!inta_n)
				begin
					out_control_logic_data = 1'b1;
					control_logic_data     = vector_high;
				end
			ack_poll:
				if (read)
				begin
					out_control_logic_data = 1'b1;
					if (ack_levels != '0)
						control_logic_data = {`PIC_POLL_FLAG, level_num};
				end
			default: ;
		endcase
	end

endmodule

// File: logic/pic_control_logic.sv
`timescale 1ns/1ps

module pic_control_logic (
	input  logic                  clk,
	input  logic                  rst_n,
	input  pic_cmd_pkg::data_t    internal_data_bus,
	input  logic                  icw_1,
	input  logic                  icw_2_4,
	input  logic                  ocw_1,
	input  logic                  ocw_2,
	input  logic                  ocw_3,
	input  logic                  read,
	input  logic                  inta_n,
	input  pic_cmd_pkg::irq_vec_t interrupt,
	input  pic_cmd_pkg::irq_vec_t highest_level_in_service,
	output logic                  interrupt_to_cpu,
	output logic                  out_control_logic_data,
	output pic_cmd_pkg::data_t    control_logic_data,
	output logic                  level_triggered,
	output logic                  enable_read_register,
	output logic                  read_register_isr_or_irr,
	output pic_cmd_pkg::irq_vec_t interrupt_mask,
	output pic_cmd_pkg::irq_vec_t end_of_interrupt,
	output logic                  freeze,
	output logic                  latch_in_service,
	output pic_cmd_pkg::irq_vec_t clear_interrupt_request
);
	import pic_cmd_pkg::*;

	logic                    init_done;
	call_base_t              call_base;
	logic                    interval_4;
	logic                    auto_eoi;
	data_t                   vector_high;
	logic                    poll_command;
	logic                    ack_done;
	irq_vec_t                ack_levels;
	pic_ack_pkg::ack_state_t ack_state;

	icw_sequencer i_icw_sequencer (
		.clk(clk), .rst_n(rst_n), .internal_data_bus(internal_data_bus),
		.icw_1(icw_1), .icw_2_4(icw_2_4), .init_done(init_done),
		.call_base(call_base), .interval_4(interval_4),
		.single_mode(), // Consumed inside the ICW sequence only.
		.level_triggered(level_triggered), .auto_eoi(auto_eoi),
		.vector_high(vector_high)
	);

	ocw_registers i_ocw_registers (
		.clk(clk), .rst_n(rst_n), .internal_data_bus(internal_data_bus),
		.init_done(init_done), .ocw_1(ocw_1), .ocw_2(ocw_2), .ocw_3(ocw_3),
		.auto_eoi(auto_eoi), .ack_done(ack_done), .ack_levels(ack_levels),
		.highest_level_in_service(highest_level_in_service),
		.interrupt_mask(interrupt_mask), .enable_read_register(enable_read_register),
		.read_register_isr_or_irr(read_register_isr_or_irr),
		.poll_command(poll_command), .end_of_interrupt(end_of_interrupt)
	);

	ack_sequencer i_ack_sequencer (
		.clk(clk), .rst_n(rst_n), .icw_1(icw_1), .inta_n(inta_n), .read(read),
		.poll_command(poll_command), .interrupt(interrupt), .ack_state(ack_state),
		.ack_levels(ack_levels), .ack_done(ack_done),
		.latch_in_service(latch_in_service), .freeze(freeze),
		.clear_interrupt_request(clear_interrupt_request),
		.interrupt_to_cpu(interrupt_to_cpu)
	);

	vector_driver i_vector_driver (
		.ack_state(ack_state), .inta_n(inta_n), .read(read),
		.ack_levels(ack_levels), .call_base(call_base), .interval_4(interval_4),
		.vector_high(vector_high), .out_control_logic_data(out_control_logic_data),
		.control_logic_data(control_logic_data)
	);

endmodule

// File: testbench/pic_control_logic_sva.sv
`timescale 1ns/1ps
`include "pic_macros.svh"

module pic_control_logic_sva (
	input logic                  clk,
	input logic                  rst_n,
	input pic_cmd_pkg::data_t    internal_data_bus,
	input logic                  icw_1,
	input logic                  icw_2_4,
	input logic                  ocw_1,
	input logic                  ocw_2,
	input logic                  ocw_3,
	input logic                  read,
	input logic                  inta_n,
	input pic_cmd_pkg::irq_vec_t interrupt,
	input pic_cmd_pkg::irq_vec_t highest_level_in_service,
	input logic                  interrupt_to_cpu,
	input logic                  out_control_logic_data,
	input pic_cmd_pkg::data_t    control_logic_data,
	input logic                  level_triggered,
	input logic                  enable_read_register,
	input logic                  read_register_isr_or_irr,
	input pic_cmd_pkg::irq_vec_t interrupt_mask,
	input pic_cmd_pkg::irq_vec_t end_of_interrupt,
	input logic                  freeze,
	input logic                  latch_in_service,
	input pic_cmd_pkg::irq_vec_t clear_interrupt_request
);
	import pic_cmd_pkg::*;

	int         fail_count = 0;
	data_t      icw1_q;
	data_t      icw2_q;
	logic       want_icw2;
	logic [1:0] icw_left; // ICW2 to ICW4 writes still expected.
	logic       aeoi_q;
	logic       ready;
	irq_vec_t   served; // Request taken at the start of a sequence.
	logic       eoi_cmd;
	logic       inta_q;
	logic       read_q;
	logic       inta_fall;
	logic       inta_rise;
	logic       read_fall;
	logic       acking;  // From the first INTA fall to the third rise.
	logic [1:0] rises;
	logic       polling;
	logic       ack_start;
	logic       ack_end;
	logic       poll_start;
	logic       poll_end;
	logic       busy_next;

	function automatic irq_num_t lowest_level(input irq_vec_t v);
		irq_num_t n;
		n = '0;
		for (int i = 7; i >= 0; i--)
			if (v[i])
				n = i[2:0];
		return n;
	endfunction

	function automatic data_t low_byte(input data_t icw1, input irq_vec_t v);
		if (icw1[`PIC_ICW1_ADI])
			return {icw1[7:5], lowest_level(v), 2'b00};
		return {icw1[7:6], lowest_level(v), 3'b000};
	endfunction

	function automatic data_t poll_word(input irq_vec_t v);
		if (v == '0)
			return '0;
		return {`PIC_POLL_FLAG, lowest_level(v)};
	endfunction

	task automatic report(input string name, input logic [7:0] got, input logic [7:0] exp);
		$error("Mismatch at %0t: %s is %h, expected %h", $time, name, got, exp);
		fail_count++;
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Reference view of the pins.
	assign ready      = (icw_left == '0);
	assign inta_fall  = inta_q & ~inta_n;
	assign inta_rise  = ~inta_q & inta_n;
	assign read_fall  = read_q & ~read;
	assign poll_start = !acking && !polling && ocw_3 && ready
		&& internal_data_bus[`PIC_OCW3_POLL];
	assign ack_start  = !acking && !polling && !poll_start && inta_fall;
	assign ack_end    = acking && rises == 2'd2 && inta_rise; // Third rise.
	assign poll_end   = polling && read_fall;
	assign busy_next  = ack_start || poll_start
		|| (acking && !ack_end) || (polling && !poll_end);

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			icw1_q    <= '0;
			icw2_q    <= '0;
			want_icw2 <= 1'b0;
			icw_left  <= '0;
			aeoi_q    <= 1'b0;
			inta_q    <= 1'b1;
			read_q    <= 1'b0;
			acking    <= 1'b0;
			rises     <= '0;
			polling   <= 1'b0;
			served    <= '0;
		end
		else
		begin
			inta_q <= inta_n;
			read_q <= read;
			if (icw_1)
			begin
				icw1_q    <= internal_data_bus;
				want_icw2 <= 1'b1;
				icw_left  <= 2'd1 + {1'b0, ~internal_data_bus[`PIC_ICW1_SNGL]}
					+ {1'b0, internal_data_bus[`PIC_ICW1_IC4]};
			end
			else if (icw_2_4 && icw_left != '0)
			begin
				if (want_icw2)
					icw2_q <= internal_data_bus;
				if (icw_left == 2'd1 && icw1_q[`PIC_ICW1_IC4])
					aeoi_q <= internal_data_bus[`PIC_ICW4_AEOI]; // Last word is ICW4.
				want_icw2 <= 1'b0;
				icw_left  <= icw_left - 2'd1;
			end
			if (ack_start)
			begin
				acking <= 1'b1;
				rises  <= '0;
			end
			else if (ack_end)
				acking <= 1'b0;
			else if (acking && inta_rise)
				rises <= rises + 2'd1;
			if (poll_start)
				polling <= 1'b1;
			else if (poll_end)
				polling <= 1'b0;
			if (ack_start || poll_start)
				served <= interrupt;
		end
	end

	assign eoi_cmd = ocw_2 && ready && !(aeoi_q && (ack_end || poll_end));

	default disable iff (!rst_n);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Command words.
	a_clear: assert property (@(posedge clk) icw_1 |-> clear_interrupt_request == 8'hff)
		else report("clear_interrupt_request", $sampled(clear_interrupt_request), 8'hff);
	a_ltim: assert property (@(posedge clk)
		icw_1 |=> level_triggered == $past(internal_data_bus[`PIC_ICW1_LTIM]))
		else report("level_triggered", $sampled(level_triggered),
			$past(internal_data_bus[`PIC_ICW1_LTIM]));
	a_mask_hold: assert property (@(posedge clk) ocw_1 && !ready |=> $stable(interrupt_mask))
		else report("interrupt_mask", $sampled(interrupt_mask), $past(interrupt_mask));
	a_mask_set: assert property (@(posedge clk)
		ocw_1 && ready |=> interrupt_mask == $past(internal_data_bus))
		else report("interrupt_mask", $sampled(interrupt_mask), $past(internal_data_bus));
	a_ocw3: assert property (@(posedge clk) ocw_3 && ready |=>
		{enable_read_register, read_register_isr_or_irr} == $past(internal_data_bus[1:0]))
		else report("read register select",
			$sampled({enable_read_register, read_register_isr_or_irr}),
			$past(internal_data_bus[1:0]));
	a_eoi_ns: assert property (@(posedge clk) eoi_cmd && internal_data_bus[6:5] == 2'b01
		|-> end_of_interrupt == highest_level_in_service)
		else report("end_of_interrupt", $sampled(end_of_interrupt),
			$sampled(highest_level_in_service));
	a_eoi_sp: assert property (@(posedge clk) eoi_cmd && internal_data_bus[6:5] == 2'b11
		|-> end_of_interrupt == 8'b1 << internal_data_bus[2:0])
		else report("end_of_interrupt", $sampled(end_of_interrupt),
			8'b1 << $sampled(internal_data_bus[2:0]));

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Acknowledge and poll.
	a_irq_set: assert property (@(posedge clk) interrupt != '0 |=> interrupt_to_cpu)
		else report("interrupt_to_cpu", $sampled(interrupt_to_cpu), 8'h01);
	a_irq_clr: assert property (@(posedge clk)
		(ack_end || poll_end) && interrupt == '0 |=> !interrupt_to_cpu)
		else report("interrupt_to_cpu", $sampled(interrupt_to_cpu), 8'h00);
	a_latch: assert property (@(posedge clk) latch_in_service == (ack_start || poll_start))
		else report("latch_in_service", $sampled(latch_in_service),
			$sampled(ack_start || poll_start));
	a_freeze: assert property (@(posedge clk) freeze == busy_next)
		else report("freeze", $sampled(freeze), $sampled(busy_next));
	a_vec_low: assert property (@(posedge clk) acking && rises == 2'd1 && !inta_n
		|-> out_control_logic_data && control_logic_data == low_byte(icw1_q, served))
		else report("control_logic_data", $sampled(control_logic_data),
			low_byte($sampled(icw1_q), $sampled(served)));
	a_vec_high: assert property (@(posedge clk) acking && rises == 2'd2 && !inta_n
		|-> out_control_logic_data && control_logic_data == icw2_q)
		else report("control_logic_data", $sampled(control_logic_data), $sampled(icw2_q));
	a_aeoi: assert property (@(posedge clk) (ack_end || poll_end) && !ocw_2
		|-> end_of_interrupt == (aeoi_q ? served : irq_vec_t'(0)))
		else report("end_of_interrupt", $sampled(end_of_interrupt),
			$sampled(aeoi_q ? served : irq_vec_t'(0)));
	a_poll: assert property (@(posedge clk) polling && read
		|-> out_control_logic_data && control_logic_data == poll_word(served))
		else report("control_logic_data", $sampled(control_logic_data),
			poll_word($sampled(served)));

endmodule

bind pic_control_logic pic_control_logic_sva i_sva (.*);

// File: testbench/pic_control_logic_tb.sv
`timescale 1ns/1ps

module pic_control_logic_tb;
	import pic_cmd_pkg::*;

	localparam int TIMEOUT = 50;

	logic     clk;
	logic     rst_n;
	data_t    internal_data_bus;
	logic     icw_1;
	logic     icw_2_4;
	logic     ocw_1;
	logic     ocw_2;
	logic     ocw_3;
	logic     read;
	logic     inta_n;
	irq_vec_t interrupt;
	irq_vec_t highest_level_in_service;
	logic     interrupt_to_cpu;
	logic     out_control_logic_data;
	data_t    control_logic_data;
	logic     level_triggered;
	logic     enable_read_register;
	logic     read_register_isr_or_irr;
	irq_vec_t interrupt_mask;
	irq_vec_t end_of_interrupt;
	logic     freeze;
	logic     latch_in_service;
	irq_vec_t clear_interrupt_request;
	int       seed = 7869;
	int       timeouts = 0;
	int       total;

	pic_control_logic i_pic_control_logic (.*);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Strobe selects 0 to 4 are ICW1, ICW2-4, OCW1, OCW2, OCW3.
	task automatic write_cmd(input int sel, input data_t data);
		@(posedge clk);
		internal_data_bus <= data;
		{icw_1, icw_2_4, ocw_1, ocw_2, ocw_3} <= 5'b10000 >> sel;
		@(posedge clk);
		{icw_1, icw_2_4, ocw_1, ocw_2, ocw_3} <= '0;
	endtask

	task automatic wait_cpu_irq(input logic level);
		int n;
		n = 0;
		while (interrupt_to_cpu !== level && n < TIMEOUT)
		begin
			@(posedge clk);
			n++;
		end
		if (interrupt_to_cpu !== level)
		begin
			$display("Timeout waiting for interrupt_to_cpu to become %b", level);
			timeouts++;
		end
	endtask

	task automatic wait_idle();
		int n;
		n = 0;
		while (freeze !== 1'b0 && n < TIMEOUT)
		begin
			@(posedge clk);
			n++;
		end
		if (freeze !== 1'b0)
		begin
			$display("Timeout waiting for the acknowledge sequence to return to idle");
			timeouts++;
		end
	endtask

	task automatic inta_pulse();
		@(posedge clk);
		inta_n <= 1'b0;
		repeat (2) @(posedge clk);
		inta_n <= 1'b1;
		@(posedge clk);
	endtask

	initial
	begin
		irq_vec_t lvl;
		rst_n = 1'b0;
		internal_data_bus = '0;
		{icw_1, icw_2_4, ocw_1, ocw_2, ocw_3} = '0;
		read = 1'b0;
		inta_n = 1'b1;
		interrupt = '0;
		highest_level_in_service = '0;
		repeat (8) @(posedge clk);
		rst_n <= 1'b1;

		for (int adi = 0; adi < 2; adi++)
		begin
			write_cmd(0, {3'b101, 1'b1, ~adi[0], adi[0], 2'b01}); // Cascade mode, ICW4 needed.
			write_cmd(2, 8'h5a); // Still in the ICW sequence.
			write_cmd(1, 8'h40 + 8'(adi));
			write_cmd(1, 8'h00);
			write_cmd(1, {6'b0, adi[0], 1'b1}); // Auto EOI on the second round.
			write_cmd(2, 8'hc3);
			write_cmd(4, 8'h0b);

			// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
			// Acknowledge sequence.
			lvl = 8'b1 << ($random(seed) & 7);
			@(posedge clk);
			interrupt <= lvl;
			wait_cpu_irq(1'b1);
			inta_pulse();
			interrupt <= '0;
			inta_pulse();
			inta_pulse();
			wait_cpu_irq(1'b0);

			highest_level_in_service <= 8'b1 << ($random(seed) & 7);
			write_cmd(3, 8'h20);
			write_cmd(3, 8'h60 | 8'($random(seed) & 7));

			// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
			// Poll.
			@(posedge clk);
			interrupt <= 8'b1 << ($random(seed) & 7);
			write_cmd(4, 8'h0c);
			interrupt <= '0;
			read <= 1'b1;
			repeat (2) @(posedge clk);
			read <= 1'b0;
			wait_idle();
			repeat (3) @(posedge clk);
		end

		total = i_pic_control_logic.i_sva.fail_count + timeouts;
		$display("Assertion failures: %0d, timeouts: %0d",
			i_pic_control_logic.i_sva.fail_count, timeouts);
		if (total == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

// File: files.f
+incdir+logic
logic/pic_cmd_pkg.sv
logic/pic_ack_pkg.sv
logic/icw_sequencer.sv
logic/ocw_registers.sv
logic/ack_sequencer.sv
logic/vector_driver.sv
logic/pic_control_logic.sv
testbench/pic_control_logic_sva.sv
testbench/pic_control_logic_tb.sv

// File: Bender.yml
package:
  name: pic_control_logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/pic_cmd_pkg.sv
      - logic/pic_ack_pkg.sv
      - logic/icw_sequencer.sv
      - logic/ocw_registers.sv
      - logic/ack_sequencer.sv
      - logic/vector_driver.sv
      - logic/pic_control_logic.sv
  - target: test
    include_dirs:
      - logic
    files:
      - testbench/pic_control_logic_sva.sv
      - testbench/pic_control_logic_tb.sv
